// ==== Bender.yml ====
package:
  name: cdbus_rx

sources:
  - files:
      - cdbus_line_pkg.sv
      - cdbus_frame_pkg.sv
      - cd_baud_rate.sv
      - cd_crc.sv
      - cd_rx_des.sv
      - cd_rx_frame.sv
      - cdbus_rx.sv
  - target: test
    files:
      - tb_cdbus_rx.sv

// ==== cd_baud_rate.sv ====
// dual-divisor bit timer with bit-increment and mid-bit capture strobes
`timescale 1ns/1ps

module cd_baud_rate
    import cdbus_line_pkg::*;
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic             sync,
    input  logic [div_w-1:0] div_ls,
    input  logic [div_w-1:0] div_hs,
    input  logic             sel,
    output logic             inc,
    output logic             cap
);

    logic [div_w-1:0] cnt;
    logic [div_w-1:0] div_cur;
    logic [div_w-1:0] half;
    logic             wrap;

    // divisor in use, switched by the deserializer between bytes
    assign div_cur = sel ? div_hs : div_ls;
    assign half    = div_cur >> 1;

    // >= so a shorter divisor picked mid-count still wraps
    assign wrap = (cnt >= div_cur);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // phase counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt <= '0;
        end else if (sync) begin
            // the cycle that saw the edge already counts as one
            cnt <= div_w'(1);
        end else if (wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // strobes are held off while the phase is being reloaded
    assign inc = !sync && wrap;
    assign cap = !sync && (cnt == half);

endmodule

// ==== cd_crc.sv ====
// serial crc-16 engine, one bit per strobe, held at its start value by clean
`timescale 1ns/1ps

module cd_crc
    import cdbus_line_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        clean,
    input  logic        data_clk,
    input  logic        data_in,
    output logic [15:0] crc_out
);

    logic        fb;
    logic [15:0] crc_next;

    // reflected lfsr, lsb leaves first
    assign fb       = crc_out[0] ^ data_in;
    assign crc_next = {1'b0, crc_out[15:1]} ^ (fb ? crc_poly : 16'h0000);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc_out <= crc_init;
        end else if (clean) begin
            crc_out <= crc_init;
        end else if (data_clk) begin
            crc_out <= crc_next;
        end
    end

endmodule

// ==== cd_rx_des.sv ====
// rx synchronizer, line FSM, idle counter, start/stop checks, byte shifter and break detect
`timescale 1ns/1ps

module cd_rx_des
    import cdbus_line_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic [div_w-1:0]  div_ls,
    input  logic [div_w-1:0]  div_hs,
    input  logic [idle_w-1:0] idle_wait_len,
    input  logic              force_wait_idle,
    input  logic              rx,
    output logic              bus_idle,
    output logic              rx_break,
    output logic [7:0]        data,
    output logic [15:0]       crc_data,
    output logic              data_clk
);

    des_state_t        state;
    logic              rx_meta;
    logic              rx_s;
    logic [idle_w-1:0] idle_cnt;
    // 0 is the start bit, 1..8 data, 9 the stop bit
    logic [3:0]        bit_cnt;
    logic              bit_err;
    logic              crc_clk;
    logic              baud_sync;
    logic              baud_sel;
    logic              bit_inc;
    logic              bit_cap;
    logic              start_edge;

    assign bus_idle   = (state == st_bus_idle);
    assign start_edge = (state == st_wait_data) && !rx_s;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input synchronizer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the line idles high
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= st_wait_idle;
            baud_sync <= 1'b0;
            baud_sel  <= 1'b0;
        end else begin
            baud_sync <= 1'b0;

            case (state)
                st_wait_idle: begin
                    baud_sel <= 1'b0;
                    if (idle_cnt >= idle_wait_len) begin
                        state <= st_bus_idle;
                    end
                end

                st_wait_data: begin
                    if (!rx_s) begin
                        state    <= st_data;
                        // every byte after the first one runs at the high rate
                        baud_sel <= 1'b1;
                    end else if (idle_cnt >= idle_wait_len) begin
                        state <= st_bus_idle;
                    end
                end

                st_bus_idle: begin
                    baud_sel  <= 1'b0;
                    // keep the timer parked until a start bit shows up
                    baud_sync <= 1'b1;
                    if (!rx_s) begin
                        state     <= st_data;
                        baud_sync <= 1'b0;
                    end
                end

                st_data: begin
                    if (data_clk) begin
                        state     <= st_wait_data;
                        baud_sel  <= 1'b0;
                        baud_sync <= 1'b1;
                    end
                end

                default: state <= st_wait_idle;
            endcase

            if (force_wait_idle || bit_err || rx_break) begin
                state <= st_wait_idle;
            end
        end
    end

    // any low level restarts the idle bit period count
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idle_cnt <= '0;
        end else if (state == st_data || !rx_s) begin
            idle_cnt <= '0;
        end else if (bit_inc && idle_cnt != '1) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bit sampling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc_clk  <= 1'b0;
            bit_err  <= 1'b0;
            rx_break <= 1'b0;
            data_clk <= 1'b0;
            bit_cnt  <= '0;
            data     <= '0;
        end else begin
            crc_clk  <= 1'b0;
            bit_err  <= 1'b0;
            rx_break <= 1'b0;
            data_clk <= 1'b0;

            if (state != st_data) begin
                bit_cnt <= '0;
            end else if (bit_cap) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd0) begin
                    // start bit gone high at mid-bit means a glitch
                    if (rx_s) begin
                        bit_err <= 1'b1;
                    end
                end else if (bit_cnt == 4'd9) begin
                    bit_cnt <= '0;
                    if (!rx_s) begin
                        // all zeros with a low stop bit is a break
                        if (data == 8'h00) begin
                            rx_break <= 1'b1;
                        end else begin
                            bit_err <= 1'b1;
                        end
                    end else begin
                        data_clk <= 1'b1;
                    end
                end else begin
                    data    <= {rx_s, data[7:1]};
                    crc_clk <= 1'b1;
                end
            end
        end
    end

    cd_baud_rate u_baud (
        .clk     (clk),
        .reset_n (reset_n),
        .sync    (baud_sync || start_edge),
        .div_ls  (div_ls),
        .div_hs  (div_hs),
        .sel     (baud_sel),
        .inc     (bit_inc),
        .cap     (bit_cap)
    );

    // the bit just shifted in sits in data[7] when crc_clk fires
    cd_crc u_crc (
        .clk      (clk),
        .reset_n  (reset_n),
        .clean    (state == st_bus_idle),
        .data_clk (crc_clk),
        .data_in  (data[7]),
        .crc_out  (crc_data)
    );

endmodule

// ==== cd_rx_frame.sv ====
// frame assembler with byte counting, address filter, crc check and frame events
`timescale 1ns/1ps

module cd_rx_frame
    import cdbus_frame_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [7:0]  local_addr,
    input  logic [7:0]  data,
    input  logic        data_clk,
    input  logic [15:0] crc_data,
    input  logic        bus_idle,
    input  logic        rx_break,
    output logic [7:0]  rx_byte,
    output logic [7:0]  rx_byte_idx,
    output logic        rx_byte_valid,
    output logic        frame_ok,
    output logic        frame_err,
    output frame_err_t  frame_err_code
);

    // nine bits hold up to 3 + 255 + 2 bytes
    logic [8:0] byte_cnt;
    logic [8:0] total;
    logic       reject;
    logic       done;
    logic       idle_d;
    logic       dst_pend;
    logic [7:0] src_byte;
    logic [7:0] dst_byte;
    logic       addr_hit;
    logic       last_byte;
    logic       live;
    logic       hdr_go;
    logic       body_go;
    logic       ok_go;
    logic       crc_go;
    logic       short_go;
    logic       break_go;

    assign addr_hit  = (data == local_addr) || (data == bcast_addr);
    // total is only loaded once the length byte is in
    assign last_byte = (byte_cnt >= 9'(hdr_len)) && (byte_cnt == total - 9'd1);
    // frame neither finished nor filtered out
    assign live      = !done && !reject;

    // the source byte waits for the address decision and goes out ahead of dst
    assign hdr_go   = data_clk && live && (byte_cnt == 9'd1) && addr_hit;
    assign body_go  = data_clk && live && (byte_cnt > 9'd1);

    assign ok_go    = data_clk && live && last_byte && (crc_data == 16'h0000);
    assign crc_go   = data_clk && live && last_byte && (crc_data != 16'h0000);
    assign short_go = bus_idle && !idle_d && (byte_cnt != 9'd0) && live;
    assign break_go = !bus_idle && rx_break && live;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt      <= '0;
            total         <= '0;
            reject        <= 1'b0;
            done          <= 1'b0;
            idle_d        <= 1'b0;
            dst_pend      <= 1'b0;
            rx_byte_valid <= 1'b0;
            frame_ok      <= 1'b0;
            frame_err     <= 1'b0;
        end else begin
            idle_d        <= bus_idle;
            dst_pend      <= hdr_go;
            rx_byte_valid <= hdr_go || body_go || dst_pend;
            frame_ok      <= ok_go;
            frame_err     <= crc_go || short_go || break_go;

            if (bus_idle) begin
                byte_cnt <= '0;
                reject   <= 1'b0;
                done     <= 1'b0;
            end else if (rx_break) begin
                // nothing more until the bus goes idle again
                done <= 1'b1;
            end else if (data_clk && !done) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == 9'd1 && !addr_hit) begin
                    reject <= 1'b1;
                end
                if (byte_cnt == 9'd2) begin
                    total <= 9'(hdr_len) + {1'b0, data} + 9'(crc_len);
                end
                // rejected frames close here too, just without an event
                if (last_byte) begin
                    done <= 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte and error payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            src_byte       <= '0;
            dst_byte       <= '0;
            rx_byte        <= '0;
            rx_byte_idx    <= '0;
            frame_err_code <= frame_err_t'(2'd0);
        end else begin
            if (data_clk && byte_cnt == 9'd0) begin
                src_byte <= data;
            end
            if (data_clk && byte_cnt == 9'd1) begin
                dst_byte <= data;
            end

            if (hdr_go) begin
                rx_byte     <= src_byte;
                rx_byte_idx <= 8'd0;
            end else if (dst_pend) begin
                rx_byte     <= dst_byte;
                rx_byte_idx <= 8'd1;
            end else if (body_go) begin
                rx_byte     <= data;
                rx_byte_idx <= byte_cnt[7:0];
            end

            if (short_go) begin
                frame_err_code <= err_short;
            end else if (break_go) begin
                frame_err_code <= err_break;
            end else if (crc_go) begin
                frame_err_code <= err_crc;
            end
        end
    end

endmodule

// ==== cdbus_frame_pkg.sv ====
// frame layout constants and the frame error code type
package cdbus_frame_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // header is src, dst, len
    localparam int hdr_len = 3;
    // crc trails the payload, low byte first
    localparam int crc_len = 2;

    localparam logic [7:0] bcast_addr = 8'hff;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // error classes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // zero is left unused so a stuck code stands out
    typedef enum logic [1:0] {
        err_crc   = 2'd1,
        err_short = 2'd2,
        err_break = 2'd3
    } frame_err_t;

endpackage

// ==== cdbus_line_pkg.sv ====
// line-level widths, CRC constants and the deserializer state encoding
package cdbus_line_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int div_w  = 16;
    localparam int idle_w = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // crc-16 modbus, reflected form
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [15:0] crc_init = 16'hffff;
    localparam logic [15:0] crc_poly = 16'ha001;

    // one-hot line states
    typedef enum logic [3:0] {
        st_wait_idle = 4'b0001,
        st_wait_data = 4'b0010,
        st_bus_idle  = 4'b0100,
        st_data      = 4'b1000
    } des_state_t;

endpackage

// ==== cdbus_rx.sv ====
// receive top level, deserializer feeding the frame assembler
`timescale 1ns/1ps

module cdbus_rx
    import cdbus_line_pkg::*;
    import cdbus_frame_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              rx,
    input  logic [div_w-1:0]  div_ls,
    input  logic [div_w-1:0]  div_hs,
    input  logic [idle_w-1:0] idle_wait_len,
    input  logic [7:0]        local_addr,
    input  logic              force_wait_idle,
    output logic              bus_idle,
    output logic [7:0]        rx_byte,
    output logic [7:0]        rx_byte_idx,
    output logic              rx_byte_valid,
    output logic              frame_ok,
    output logic              frame_err,
    output frame_err_t        frame_err_code
);

    // byte path between the two stages
    logic [7:0]  des_data;
    logic [15:0] des_crc;
    logic        des_data_clk;
    logic        des_break;

    cd_rx_des u_des (
        .clk             (clk),
        .reset_n         (reset_n),
        .div_ls          (div_ls),
        .div_hs          (div_hs),
        .idle_wait_len   (idle_wait_len),
        .force_wait_idle (force_wait_idle),
        .rx              (rx),
        .bus_idle        (bus_idle),
        .rx_break        (des_break),
        .data            (des_data),
        .crc_data        (des_crc),
        .data_clk        (des_data_clk)
    );

    cd_rx_frame u_frame (
        .clk            (clk),
        .reset_n        (reset_n),
        .local_addr     (local_addr),
        .data           (des_data),
        .data_clk       (des_data_clk),
        .crc_data       (des_crc),
        .bus_idle       (bus_idle),
        .rx_break       (des_break),
        .rx_byte        (rx_byte),
        .rx_byte_idx    (rx_byte_idx),
        .rx_byte_valid  (rx_byte_valid),
        .frame_ok       (frame_ok),
        .frame_err      (frame_err),
        .frame_err_code (frame_err_code)
    );

endmodule

// ==== tb_cdbus_rx.sv ====
// testbench for the receive top level with serial driver, xorshift, reference model and checker
`timescale 1ns/1ps

module tb_cdbus_rx
    import cdbus_line_pkg::*;
    import cdbus_frame_pkg::*;
();

    localparam int ls_div    = 15;
    localparam int hs_div    = 7;
    localparam int idle_len  = 10;
    localparam logic [7:0] node_addr = 8'h05;
    localparam int ls_bit    = ls_div + 1;
    localparam int hs_bit    = hs_div + 1;
    localparam int gap_cycles = (idle_len + 4) * ls_bit;

    // longest frame is header, 12 payload bytes and crc
    localparam int n_directed   = 7;
    localparam int n_random     = 24;
    localparam int max_frame    = hdr_len + 12 + crc_len;
    localparam int frame_cycles = 10 * ls_bit + (max_frame - 1) * 10 * hs_bit + gap_cycles;
    localparam int cycle_limit  = (frame_cycles * (n_directed + n_random) * 3) / 2 + 1000;

    localparam logic [1:0] ev_byte = 2'd0;
    localparam logic [1:0] ev_ok   = 2'd1;
    localparam logic [1:0] ev_err  = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        logic [7:0] idx;
        logic [7:0] val;
        logic [1:0] code;
    } rx_event_t;

    logic              clk;
    logic              reset_n;
    logic              rx;
    logic [div_w-1:0]  div_ls;
    logic [div_w-1:0]  div_hs;
    logic [idle_w-1:0] idle_wait_len;
    logic [7:0]        local_addr;
    logic              force_wait_idle;
    logic              bus_idle;
    logic [7:0]        rx_byte;
    logic [7:0]        rx_byte_idx;
    logic              rx_byte_valid;
    logic              frame_ok;
    logic              frame_err;
    frame_err_t        frame_err_code;

    logic [31:0] rng_state;
    logic [7:0]  frame_q[$];
    rx_event_t   exp_q[$];
    int          errors;
    int          checks;
    int          cycle_cnt;

    cdbus_rx u_dut (
        .clk             (clk),
        .reset_n         (reset_n),
        .rx              (rx),
        .div_ls          (div_ls),
        .div_hs          (div_hs),
        .idle_wait_len   (idle_wait_len),
        .local_addr      (local_addr),
        .force_wait_idle (force_wait_idle),
        .bus_idle        (bus_idle),
        .rx_byte         (rx_byte),
        .rx_byte_idx     (rx_byte_idx),
        .rx_byte_valid   (rx_byte_valid),
        .frame_ok        (frame_ok),
        .frame_err       (frame_err),
        .frame_err_code  (frame_err_code)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [7:0] rand_byte();
        rng_state = xorshift(rng_state);
        return rng_state[15:8];
    endfunction

    // modbus crc-16 over the first n bytes of the frame
    function automatic logic [15:0] crc16(input int n);
        logic [15:0] c;
        c = 16'hffff;
        for (int i = 0; i < n; i++) begin
            c = c ^ {8'h00, frame_q[i]};
            for (int b = 0; b < 8; b++) begin
                if (c[0]) begin
                    c = (c >> 1) ^ 16'ha001;
                end else begin
                    c = c >> 1;
                end
            end
        end
        return c;
    endfunction

    function automatic string kind_name(input logic [1:0] k);
        case (k)
            ev_byte: return "rx_byte_valid";
            ev_ok:   return "frame_ok";
            default: return "frame_err";
        endcase
    endfunction

    task automatic build_frame(input logic [7:0] src, input logic [7:0] dst,
                               input logic [7:0] len);
        logic [15:0] crc;
        frame_q.delete();
        frame_q.push_back(src);
        frame_q.push_back(dst);
        frame_q.push_back(len);
        for (int i = 0; i < len; i++) begin
            frame_q.push_back(rand_byte());
        end
        crc = crc16(frame_q.size());
        frame_q.push_back(crc[7:0]);
        frame_q.push_back(crc[15:8]);
    endtask

    task automatic push_event(input logic [1:0] kind, input logic [7:0] idx,
                              input logic [7:0] val, input logic [1:0] code);
        rx_event_t e;
        e.kind = kind;
        e.idx  = idx;
        e.val  = val;
        e.code = code;
        exp_q.push_back(e);
    endtask

    // expected events when only the first n bytes go out, cut_code ends a partial frame
    task automatic expect_frame(input int n, input logic [1:0] cut_code);
        logic [15:0] crc;
        int          last;
        logic        hit;
        hit = (n < 2) || (frame_q[1] == node_addr) || (frame_q[1] == 8'hff);
        if (hit) begin
            if (n >= 2) begin
                for (int i = 0; i < n; i++) begin
                    push_event(ev_byte, 8'(i), frame_q[i], 2'd0);
                end
            end
            if (n == frame_q.size()) begin
                last = n - 2;
                crc  = crc16(last);
                if (frame_q[last] == crc[7:0] && frame_q[last + 1] == crc[15:8]) begin
                    push_event(ev_ok, 8'd0, 8'd0, 2'd0);
                end else begin
                    push_event(ev_err, 8'd0, 8'd0, err_crc);
                end
            end else begin
                push_event(ev_err, 8'd0, 8'd0, cut_code);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // serial line driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bits[0] leaves first
    task automatic send_bits(input logic [9:0] bits, input int cycles);
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            repeat (cycles) @(negedge clk);
        end
    endtask

    // first byte at the low rate, the rest at the high rate
    task automatic send_frame(input int n, input logic with_break);
        for (int i = 0; i < n; i++) begin
            send_bits({1'b1, frame_q[i], 1'b0}, (i == 0) ? ls_bit : hs_bit);
        end
        if (with_break) begin
            send_bits(10'h000, (n == 0) ? ls_bit : hs_bit);
        end
        rx = 1'b1;
    endtask

    task automatic idle_gap();
        rx = 1'b1;
        repeat (gap_cycles) @(negedge clk);
        assert (bus_idle) else begin
            errors++;
            $display("ERROR bus_idle still low at the end of the idle gap at %0t", $time);
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("ERROR %0d expected events never arrived by %0t", exp_q.size(), $time);
        end
        exp_q.delete();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checker
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_strobe(input logic [1:0] kind);
        rx_event_t e;
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("ERROR %s strobe at %0t with no event expected", kind_name(kind), $time);
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            checks++;
            assert (e.kind == kind) else begin
                errors++;
                $display("ERROR %s strobe at %0t where %s was expected",
                         kind_name(kind), $time, kind_name(e.kind));
            end
            if (e.kind == kind && kind == ev_byte) begin
                assert (rx_byte == e.val) else begin
                    errors++;
                    $display("FAILED rx_byte: got %h, expected %h", rx_byte, e.val);
                end
                assert (rx_byte_idx == e.idx) else begin
                    errors++;
                    $display("FAILED rx_byte_idx: got %h, expected %h", rx_byte_idx, e.idx);
                end
            end
            if (e.kind == kind && kind == ev_err) begin
                assert (frame_err_code == e.code) else begin
                    errors++;
                    $display("FAILED frame_err_code: got %h, expected %h", frame_err_code, e.code);
                end
            end
        end
    endtask

    // outputs settle after the rising edge, read them at the falling edge
    always @(negedge clk) begin
        if (rx_byte_valid) begin
            check_strobe(ev_byte);
        end
        if (frame_ok) begin
            check_strobe(ev_ok);
        end
        if (frame_err) begin
            check_strobe(ev_err);
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, errors: %0d", cycle_limit, errors);
        $display(">>> FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [7:0] src;
        logic [7:0] dst;
        logic [7:0] pick;
        logic [7:0] len;
        rx              = 1'b1;
        reset_n         = 1'b0;
        force_wait_idle = 1'b0;
        div_ls          = div_w'(ls_div);
        div_hs          = div_w'(hs_div);
        idle_wait_len   = idle_w'(idle_len);
        local_addr      = node_addr;
        rng_state       = 32'd7;
        errors          = 0;
        checks          = 0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        idle_gap();

        // dual-rate frame to this node
        build_frame(8'h21, node_addr, 8'd6);
        expect_frame(frame_q.size(), err_short);
        send_frame(frame_q.size(), 1'b0);
        idle_gap();

        // one crc bit flipped in the low crc byte
        build_frame(8'h22, node_addr, 8'd4);
        frame_q[frame_q.size() - 2] = frame_q[frame_q.size() - 2] ^ 8'h10;
        expect_frame(frame_q.size(), err_short);
        send_frame(frame_q.size(), 1'b0);
        idle_gap();

        // foreign destination, then broadcast
        build_frame(8'h23, 8'h3c, 8'd5);
        expect_frame(frame_q.size(), err_short);
        send_frame(frame_q.size(), 1'b0);
        idle_gap();
        build_frame(8'h24, 8'hff, 8'd3);
        expect_frame(frame_q.size(), err_short);
        send_frame(frame_q.size(), 1'b0);
        idle_gap();

        // break after five bytes, then a clean frame
        build_frame(8'h25, node_addr, 8'd8);
        expect_frame(5, err_break);
        send_frame(5, 1'b1);
        idle_gap();
        build_frame(8'h26, node_addr, 8'd2);
        expect_frame(frame_q.size(), err_short);
        send_frame(frame_q.size(), 1'b0);
        idle_gap();

        // header only, then the line goes quiet
        build_frame(8'h27, node_addr, 8'd4);
        expect_frame(3, err_short);
        send_frame(3, 1'b0);
        idle_gap();

        for (int f = 0; f < n_random; f++) begin
            src  = rand_byte();
            pick = rand_byte();
            if (pick[1:0] == 2'd0) begin
                dst = node_addr;
            end else if (pick[1:0] == 2'd1) begin
                dst = 8'hff;
            end else begin
                dst = rand_byte();
            end
            len = rand_byte() % 13;
            build_frame(src, dst, len);
            expect_frame(frame_q.size(), err_short);
            send_frame(frame_q.size(), 1'b0);
            idle_gap();
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
cdbus_line_pkg.sv
cdbus_frame_pkg.sv
cd_baud_rate.sv
cd_crc.sv
cd_rx_des.sv
cd_rx_frame.sv
cdbus_rx.sv
tb_cdbus_rx.sv
